// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_ai_ch
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "test: PASS"; else echo "test: FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
source/ai_ch_pkg.sv
source/spi_byte_engine.sv
source/adc_sequencer.sv
source/ch_config_regs.sv
source/sample_conditioner.sv
source/ch_readback.sv
source/ai_ch_top.sv
sim/tb_clock.sv
sim/tb_ai_ch.sv

// ==== sim/tb_ai_ch.sv ====
module tb_ai_ch;

    localparam int SEED       = 44170;
    localparam int N_SAMPLES  = 52;                     // 4 + 10 + 3 * 12 + 2
    localparam int MAX_CYCLES = N_SAMPLES * 600 + 5000; // plus setup and idle time
    localparam ai_ch_pkg::addr_t REG_ADDR [14] = '{
        12'h000, 12'h005, 12'h007, 12'h008, 12'h00B, 12'h00C, 12'h00D,
        12'h00E, 12'h800, 12'h801, 12'h802, 12'h804, 12'h805, 12'h806
    };

    logic               clk;
    logic               rst_n;
    logic               par_wr_en;
    ai_ch_pkg::addr_t   par_addr;
    ai_ch_pkg::byte_t   par_data;
    logic               rd_en;
    ai_ch_pkg::addr_t   rd_addr;
    ai_ch_pkg::byte_t   rd_data;
    logic               spi_clk;
    logic               spi_mosi;
    logic               spi_miso = 1'b1;
    logic               spi_cs_n;

    int                 n_checks = 0;
    int                 n_errors = 0;
    int                 cycles   = 0;
    int                 n_reads  = 0;
    int                 frm_len_q [$];
    logic [31:0]        frm_val_q [$];
    ai_ch_pkg::proc_t   hist_q [$];
    ai_ch_pkg::proc_t   exp_proc;
    ai_ch_pkg::sample_t k_s;
    ai_ch_pkg::sample_t b_s;
    ai_ch_pkg::proc_t   hi_s;
    ai_ch_pkg::proc_t   lo_s;
    ai_ch_pkg::byte_t   ft_s;
    ai_ch_pkg::byte_t   ff_s;

    // converter model state
    logic               prev_sck  = 1'b1;
    logic               prev_cs   = 1'b1;
    logic               is_read   = 1'b0;
    int                 bit_n     = 0;
    int                 ready_cnt = -1;
    logic [7:0]         sh;
    logic [31:0]        frm_val;
    logic [23:0]        code;
    logic [23:0]        miso_sr;

    tb_clock #(.PERIOD(8), .RST_CYCLES(3)) tb_clock_i (.clk, .rst_n);

    ai_ch_top #(
        .SPI_SPEED (32),
        .PACK_GAP  (40)
    ) ai_ch_top_i (
        .clk, .rst_n, .par_wr_en, .par_addr, .par_data, .rd_en, .rd_addr, .rd_data,
        .spi_clk, .spi_mosi, .spi_miso, .spi_cs_n
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    function automatic ai_ch_pkg::proc_t calibrate(input logic [23:0] c,
                                                   input logic [23:0] kk,
                                                   input logic [23:0] bb);
        longint v;
        longint lim;
        lim = longint'(24'hFF_FFFF) << 23;
        v   = longint'(c) * longint'(kk);
        if (bb[23])
            v = v - (longint'(bb[22:0]) << 15);
        else
            v = v + (longint'(bb[22:0]) << 15);
        if (v < 0)
            v = 0;
        else if (v > lim)
            v = lim;
        return v[46:31];  // top of bits 46:23
    endfunction

    function automatic ai_ch_pkg::proc_t filter_ref(input ai_ch_pkg::byte_t ft,
                                                    input ai_ch_pkg::byte_t ff);
        int          taps;
        int unsigned sum;
        if (ft == 8'h00)
            return hist_q[0];
        if (ft != 8'h01 || ff > 8'd2)
            return '0;
        taps = 8 >> ff;
        sum  = 0;
        for (int i = 0; i < taps; i++)
            sum = sum + 32'(hist_q[i]);
        return 16'(sum / taps);
    endfunction

    // mode 3 slave, sampled just after each clock edge
    always begin
        @(posedge clk);
        #1;
        if (!spi_cs_n && prev_cs) begin
            bit_n     = 0;
            frm_val   = '0;
            is_read   = 1'b0;
            ready_cnt = -1;
        end
        if (!spi_cs_n && spi_clk && !prev_sck) begin
            sh    = {sh[6:0], spi_mosi};
            bit_n = bit_n + 1;
            if (bit_n % 8 == 0)
                frm_val = {frm_val[23:0], sh};
            if (bit_n == 8 && sh == 8'h58) begin
                is_read = 1'b1;
                code    = 24'($urandom);
                miso_sr = code;
            end
        end
        if (!spi_cs_n && !spi_clk && prev_sck) begin
            if (is_read && bit_n >= 8) begin
                spi_miso = miso_sr[23];
                miso_sr  = miso_sr << 1;
            end else begin
                spi_miso = 1'b1;
            end
        end
        if (spi_cs_n && !prev_cs) begin
            spi_miso  = 1'b1;
            ready_cnt = $urandom_range(60, 0);
            frm_len_q.push_back(bit_n / 8);
            frm_val_q.push_back(frm_val);
            if (is_read) begin
                hist_q.push_front(calibrate(code, k_s, b_s));
                void'(hist_q.pop_back());
                exp_proc = filter_ref(ft_s, ff_s);
                n_reads  = n_reads + 1;
            end
        end else if (spi_cs_n && ready_cnt == 0) begin
            spi_miso = 1'b0;  // conversion ready
        end else if (spi_cs_n && ready_cnt > 0) begin
            ready_cnt = ready_cnt - 1;
        end
        prev_sck = spi_clk;
        prev_cs  = spi_cs_n;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d errors", cycles, n_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // host side tasks
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_reg(input ai_ch_pkg::addr_t a, input ai_ch_pkg::byte_t d);
        par_wr_en = 1'b1;
        par_addr  = a;
        par_data  = d;
        tick();
        par_wr_en = 1'b0;
    endtask

    task automatic read_reg(input ai_ch_pkg::addr_t a, output ai_ch_pkg::byte_t d);
        rd_en   = 1'b1;
        rd_addr = a;
        tick();
        rd_en = 1'b0;
        d     = rd_data;
    endtask

    task automatic set_k(input ai_ch_pkg::sample_t v);
        k_s = v;
        write_reg(12'h800, v[7:0]);
        write_reg(12'h801, v[15:8]);
        write_reg(12'h802, v[23:16]);
    endtask

    task automatic set_b(input ai_ch_pkg::sample_t v);
        b_s = v;
        write_reg(12'h804, v[7:0]);
        write_reg(12'h805, v[15:8]);
        write_reg(12'h806, v[23:16]);
    endtask

    task automatic set_limits(input ai_ch_pkg::proc_t hi, input ai_ch_pkg::proc_t lo);
        hi_s = hi;
        lo_s = lo;
        write_reg(12'h00D, hi[7:0]);
        write_reg(12'h00E, hi[15:8]);
        write_reg(12'h00B, lo[7:0]);
        write_reg(12'h00C, lo[15:8]);
    endtask

    task automatic set_filter(input ai_ch_pkg::byte_t t, input ai_ch_pkg::byte_t f);
        ft_s = t;
        ff_s = f;
        write_reg(12'h007, t);
        write_reg(12'h008, f);
    endtask

    task automatic check_setup_frames(input int base, input logic [15:0] cfg);
        while (frm_len_q.size() < base + 3)
            tick();
        check("frame_len", 32'(frm_len_q[base]), 32'd4);
        check("mosi_frame", frm_val_q[base], 32'hFFFF_FFFF);
        check("frame_len", 32'(frm_len_q[base + 1]), 32'd3);
        check("mosi_frame", frm_val_q[base + 1], 32'h0008_0003);
        check("frame_len", 32'(frm_len_q[base + 2]), 32'd3);
        check("mosi_frame", frm_val_q[base + 2], {16'h0010, cfg});
    endtask

    // one sample, result read 4 cycles after the read frame ends
    task automatic check_sample();
        int               seen;
        ai_ch_pkg::byte_t lo_b;
        ai_ch_pkg::byte_t hi_b;
        ai_ch_pkg::byte_t st;
        ai_ch_pkg::proc_t exp;
        seen = n_reads;
        while (n_reads == seen)
            tick();
        repeat (4) tick();
        exp = exp_proc;
        read_reg(12'h880, lo_b);
        read_reg(12'h881, hi_b);
        read_reg(12'h882, st);
        check("proc_data", 32'({hi_b, lo_b}), 32'(exp));
        check("status", 32'(st), 32'({4'd0, exp < lo_s, exp > hi_s, 2'd0}));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    initial begin
        ai_ch_pkg::byte_t   wdat [14];
        ai_ch_pkg::byte_t   rd;
        ai_ch_pkg::sample_t kv;
        ai_ch_pkg::sample_t bv;
        int                 i;
        int                 base;
        void'($urandom(SEED));
        par_wr_en = 1'b0;
        par_addr  = '0;
        par_data  = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        repeat (8) hist_q.push_back('0);
        wait (rst_n === 1'b1);
        tick();

        for (i = 0; i < 14; i++) begin
            wdat[i] = 8'($urandom);
            if (i == 0)
                wdat[i] = wdat[i] & 8'hFE;  // channel stays off
            write_reg(REG_ADDR[i], wdat[i]);
            read_reg(REG_ADDR[i], rd);
            check("rd_data", 32'(rd), 32'(wdat[i]));
        end
        read_reg(12'h003, rd);
        check("rd_data_unmapped", 32'(rd), 32'h0);
        read_reg(12'h883, rd);
        check("rd_data_unmapped", 32'(rd), 32'h0);

        // unity gain, voltage channel
        set_filter(8'h00, 8'h00);
        set_k(24'h80_0000);
        set_b(24'h0);
        set_limits(16'hFFFF, 16'h0000);
        write_reg(12'h005, 8'h02);
        base = frm_len_q.size();
        write_reg(12'h000, 8'h01);
        check_setup_frames(base, 16'h0091);
        repeat (4) check_sample();

        for (i = 0; i < 10; i++) begin
            kv = 24'($urandom);
            bv = 24'($urandom);
            if (i % 3 == 0) begin
                kv     = kv & 24'h00_00FF;  // offset dominates
                bv[23] = 1'b1;
            end else if (i % 3 == 1) begin
                kv = kv | 24'hC0_0000;      // past full scale
            end
            set_k(kv);
            set_b(bv);
            set_limits(16'($urandom), 16'($urandom));
            check_sample();
        end

        set_k(24'h80_0000);
        set_b(24'h0);
        for (i = 0; i < 3; i++) begin
            set_filter(8'h01, 8'(i));
            set_limits(16'($urandom), 16'($urandom));
            repeat (12) check_sample();
        end

        // disable, stay idle, restart as a current channel
        write_reg(12'h000, 8'h00);
        base = frm_len_q.size();
        repeat (400) tick();
        check("frame_count", 32'(frm_len_q.size()), 32'(base));
        write_reg(12'h005, 8'h00);
        write_reg(12'h000, 8'h01);
        check_setup_frames(base, 16'h0090);
        repeat (2) check_sample();

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== source/adc_sequencer.sv ====
module adc_sequencer #(
    parameter int SPI_SPEED = 128,
    parameter int PACK_GAP  = 5000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ai_ch_pkg::byte_t   ch_en,
    input  ai_ch_pkg::byte_t   ch_type,
    input  logic               spi_miso,
    output logic               spi_clk,
    output logic               spi_mosi,
    output logic               spi_cs_n,
    output ai_ch_pkg::sample_t raw_sample,
    output logic               sample_valid
);

    localparam logic [2:0] S_RESET  = 3'd0;
    localparam logic [2:0] S_GAP    = 3'd1;
    localparam logic [2:0] S_MODE   = 3'd2;
    localparam logic [2:0] S_CONFIG = 3'd3;
    localparam logic [2:0] S_READY  = 3'd4;
    localparam logic [2:0] S_READ   = 3'd5;
    localparam int GW = $clog2(PACK_GAP + 1);

    logic [2:0]                   state;
    logic [2:0]                   ret_st;  // stage after the gap
    logic [GW-1:0]                gap_cnt;
    logic                         miso_s1;
    logic                         miso_s2;
    logic                         run;
    logic                         issue;
    logic [15:0]                  cfg_word;
    ai_ch_pkg::byte_t [3:0]       frm_bytes;
    logic [2:0]                   frm_ntx;
    logic [2:0]                   frm_nb;
    logic                         frame_start;
    ai_ch_pkg::byte_t [3:0]       tx_bytes;
    logic [2:0]                   n_tx;
    logic [2:0]                   n_bytes;
    logic                         busy;
    ai_ch_pkg::byte_t             rx_byte;
    logic                         rx_valid;

    assign run = (ch_en == ai_ch_pkg::CH_EN_ON) &&
                 (ch_type == ai_ch_pkg::CH_TYPE_I || ch_type == ai_ch_pkg::CH_TYPE_V);
    assign cfg_word = (ch_type == ai_ch_pkg::CH_TYPE_V) ? ai_ch_pkg::CONFIG_V
                                                          : ai_ch_pkg::CONFIG_I;

    assign issue = run && ((state == S_RESET && !busy) || state == S_MODE ||
                           state == S_CONFIG || (state == S_READY && !miso_s2));

    // frame contents, tx_bytes[0] goes out first
    always_comb begin
        case (state)
            S_MODE: begin
                frm_bytes = {8'hFF, ai_ch_pkg::MODE_WORD[7:0], ai_ch_pkg::MODE_WORD[15:8],
                             ai_ch_pkg::CMD_WR_MODE};
                frm_ntx   = 3'd3;
                frm_nb    = 3'd3;
            end
            S_CONFIG: begin
                frm_bytes = {8'hFF, cfg_word[7:0], cfg_word[15:8], ai_ch_pkg::CMD_WR_CONFIG};
                frm_ntx   = 3'd3;
                frm_nb    = 3'd3;
            end
            S_READY: begin
                frm_bytes = {8'hFF, 8'hFF, 8'hFF, ai_ch_pkg::CMD_RD_DATA};
                frm_ntx   = 3'd1;
                frm_nb    = 3'd4;  // three bytes back
            end
            default: begin
                frm_bytes = {4{8'hFF}};  // converter reset
                frm_ntx   = 3'd4;
                frm_nb    = 3'd4;
            end
        endcase
    end

    // miso low means conversion ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miso_s1 <= 1'b1;
            miso_s2 <= 1'b1;
        end else begin
            miso_s1 <= spi_miso;
            miso_s2 <= miso_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tx_bytes <= frm_bytes;
            n_tx     <= frm_ntx;
            n_bytes  <= frm_nb;
        end
        if (state == S_READ && rx_valid)
            raw_sample <= {raw_sample[15:0], rx_byte};  // msb first
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_RESET;
            ret_st       <= S_MODE;
            gap_cnt      <= '0;
            frame_start  <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            frame_start  <= issue;
            sample_valid <= 1'b0;
            if (!run) begin
                state <= S_RESET;
            end else begin
                case (state)
                    S_RESET: if (!busy) begin
                        ret_st <= S_MODE;
                        state  <= S_GAP;
                    end
                    S_GAP: begin
                        if (busy || frame_start)
                            gap_cnt <= '0;
                        else if (gap_cnt == GW'(PACK_GAP - 1))
                            state <= ret_st;
                        else
                            gap_cnt <= gap_cnt + 1'b1;
                    end
                    S_MODE: begin
                        ret_st <= S_CONFIG;
                        state  <= S_GAP;
                    end
                    S_CONFIG: begin
                        ret_st <= S_READY;
                        state  <= S_GAP;
                    end
                    S_READY: if (!miso_s2)
                        state <= S_READ;
                    S_READ: if (!busy && !frame_start) begin
                        sample_valid <= 1'b1;
                        gap_cnt      <= '0;
                        ret_st       <= S_READY;
                        state        <= S_GAP;
                    end
                    default: state <= S_RESET;
                endcase
            end
        end
    end

    spi_byte_engine #(
        .SPI_SPEED (SPI_SPEED)
    ) spi_byte_engine_i (
        .clk, .rst_n, .frame_start, .tx_bytes, .n_tx, .n_bytes, .spi_miso,
        .busy, .rx_byte, .rx_valid, .spi_clk, .spi_mosi, .spi_cs_n
    );

endmodule

// ==== source/ai_ch_pkg.sv ====
package ai_ch_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [11:0] addr_t;
    typedef logic [23:0] sample_t;
    typedef logic [15:0] proc_t;

    ////////////////////////////////////////////////////////////////////////////
    // host register map
    localparam addr_t ADDR_CH_EN         = 12'h000;
    localparam addr_t ADDR_CH_TYPE       = 12'h005;
    localparam addr_t ADDR_FILTER_TYPE   = 12'h007;
    localparam addr_t ADDR_FILTER_FACTOR = 12'h008;
    localparam addr_t ADDR_LOW_LIMIT     = 12'h00B;  // high byte at +1
    localparam addr_t ADDR_HIGH_LIMIT    = 12'h00D;  // high byte at +1
    localparam addr_t ADDR_K             = 12'h800;  // three bytes, lsb first
    localparam addr_t ADDR_B             = 12'h804;  // bit 23 is the sign
    localparam addr_t ADDR_RESULT        = 12'h880;
    localparam addr_t ADDR_STATUS        = 12'h882;

    // register codes
    localparam byte_t CH_EN_ON     = 8'h01;
    localparam byte_t DIAG_EN      = 8'h01;
    localparam byte_t CH_TYPE_I    = 8'h00;
    localparam byte_t CH_TYPE_V    = 8'h02;
    localparam byte_t FILT_NONE    = 8'h00;
    localparam byte_t FILT_AVERAGE = 8'h01;

    ////////////////////////////////////////////////////////////////////////////
    // converter command bytes and register words
    localparam byte_t       CMD_WR_MODE   = 8'h08;
    localparam byte_t       CMD_WR_CONFIG = 8'h10;
    localparam byte_t       CMD_RD_DATA   = 8'h58;
    localparam logic [15:0] MODE_WORD     = 16'h0003;
    localparam logic [15:0] CONFIG_I      = 16'h0090;
    localparam logic [15:0] CONFIG_V      = 16'h0091;

    localparam int CAL_FRAC = 23;  // binary point of k

endpackage

// ==== source/ai_ch_top.sv ====
module ai_ch_top #(
    parameter int SPI_SPEED = 128,
    parameter int PACK_GAP  = 5000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              par_wr_en,
    input  ai_ch_pkg::addr_t  par_addr,
    input  ai_ch_pkg::byte_t  par_data,
    input  logic              rd_en,
    input  ai_ch_pkg::addr_t  rd_addr,
    output ai_ch_pkg::byte_t  rd_data,
    output logic              spi_clk,
    output logic              spi_mosi,
    input  logic              spi_miso,
    output logic              spi_cs_n
);

    ai_ch_pkg::byte_t   ch_en;
    ai_ch_pkg::byte_t   ch_type;
    ai_ch_pkg::byte_t   filter_type;
    ai_ch_pkg::byte_t   filter_factor;
    ai_ch_pkg::sample_t k;
    ai_ch_pkg::sample_t b;
    ai_ch_pkg::proc_t   high_limit;
    ai_ch_pkg::proc_t   low_limit;
    ai_ch_pkg::sample_t raw_sample;
    logic               sample_valid;
    ai_ch_pkg::proc_t   proc_data;
    logic               high_flag;
    logic               low_flag;

    ch_config_regs ch_config_regs_i (
        .clk, .rst_n, .par_wr_en, .par_addr, .par_data,
        .ch_en, .ch_type, .filter_type, .filter_factor,
        .k, .b, .high_limit, .low_limit
    );

    adc_sequencer #(
        .SPI_SPEED (SPI_SPEED),
        .PACK_GAP  (PACK_GAP)
    ) adc_sequencer_i (
        .clk, .rst_n, .ch_en, .ch_type, .spi_miso,
        .spi_clk, .spi_mosi, .spi_cs_n, .raw_sample, .sample_valid
    );

    sample_conditioner sample_conditioner_i (
        .clk, .rst_n, .raw_sample, .sample_valid, .k, .b,
        .filter_type, .filter_factor, .high_limit, .low_limit,
        .proc_data, .high_flag, .low_flag
    );

    ch_readback ch_readback_i (
        .clk, .rst_n, .rd_en, .rd_addr,
        .ch_en, .ch_type, .filter_type, .filter_factor,
        .k, .b, .high_limit, .low_limit,
        .proc_data, .high_flag, .low_flag, .rd_data
    );

endmodule

// ==== source/ch_config_regs.sv ====
module ch_config_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               par_wr_en,
    input  ai_ch_pkg::addr_t   par_addr,
    input  ai_ch_pkg::byte_t   par_data,
    output ai_ch_pkg::byte_t   ch_en,
    output ai_ch_pkg::byte_t   ch_type,
    output ai_ch_pkg::byte_t   filter_type,
    output ai_ch_pkg::byte_t   filter_factor,
    output ai_ch_pkg::sample_t k,
    output ai_ch_pkg::sample_t b,
    output ai_ch_pkg::proc_t   high_limit,
    output ai_ch_pkg::proc_t   low_limit
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_en         <= '0;
            ch_type       <= '0;
            filter_type   <= '0;
            filter_factor <= '0;
            k             <= '0;
            b             <= '0;
            high_limit    <= '0;
            low_limit     <= '0;
        end else if (par_wr_en) begin
            case (par_addr)
                ai_ch_pkg::ADDR_CH_EN:                 ch_en            <= par_data;
                ai_ch_pkg::ADDR_CH_TYPE:               ch_type          <= par_data;
                ai_ch_pkg::ADDR_FILTER_TYPE:           filter_type      <= par_data;
                ai_ch_pkg::ADDR_FILTER_FACTOR:         filter_factor    <= par_data;
                ai_ch_pkg::ADDR_LOW_LIMIT:             low_limit[7:0]   <= par_data;
                ai_ch_pkg::ADDR_LOW_LIMIT + 12'd1:     low_limit[15:8]  <= par_data;
                ai_ch_pkg::ADDR_HIGH_LIMIT:            high_limit[7:0]  <= par_data;
                ai_ch_pkg::ADDR_HIGH_LIMIT + 12'd1:    high_limit[15:8] <= par_data;
                ai_ch_pkg::ADDR_K:                     k[7:0]           <= par_data;
                ai_ch_pkg::ADDR_K + 12'd1:             k[15:8]          <= par_data;
                ai_ch_pkg::ADDR_K + 12'd2:             k[23:16]         <= par_data;
                ai_ch_pkg::ADDR_B:                     b[7:0]           <= par_data;
                ai_ch_pkg::ADDR_B + 12'd1:             b[15:8]          <= par_data;
                ai_ch_pkg::ADDR_B + 12'd2:             b[23:16]         <= par_data;
                default: ;  // unmapped writes dropped
            endcase
        end
    end

endmodule

// ==== source/ch_readback.sv ====
module ch_readback (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd_en,
    input  ai_ch_pkg::addr_t   rd_addr,
    input  ai_ch_pkg::byte_t   ch_en,
    input  ai_ch_pkg::byte_t   ch_type,
    input  ai_ch_pkg::byte_t   filter_type,
    input  ai_ch_pkg::byte_t   filter_factor,
    input  ai_ch_pkg::sample_t k,
    input  ai_ch_pkg::sample_t b,
    input  ai_ch_pkg::proc_t   high_limit,
    input  ai_ch_pkg::proc_t   low_limit,
    input  ai_ch_pkg::proc_t   proc_data,
    input  logic               high_flag,
    input  logic               low_flag,
    output ai_ch_pkg::byte_t   rd_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            case (rd_addr)
                ai_ch_pkg::ADDR_CH_EN:              rd_data <= ch_en;
                ai_ch_pkg::ADDR_CH_TYPE:            rd_data <= ch_type;
                ai_ch_pkg::ADDR_FILTER_TYPE:        rd_data <= filter_type;
                ai_ch_pkg::ADDR_FILTER_FACTOR:      rd_data <= filter_factor;
                ai_ch_pkg::ADDR_LOW_LIMIT:          rd_data <= low_limit[7:0];
                ai_ch_pkg::ADDR_LOW_LIMIT + 12'd1:  rd_data <= low_limit[15:8];
                ai_ch_pkg::ADDR_HIGH_LIMIT:         rd_data <= high_limit[7:0];
                ai_ch_pkg::ADDR_HIGH_LIMIT + 12'd1: rd_data <= high_limit[15:8];
                ai_ch_pkg::ADDR_K:                  rd_data <= k[7:0];
                ai_ch_pkg::ADDR_K + 12'd1:          rd_data <= k[15:8];
                ai_ch_pkg::ADDR_K + 12'd2:          rd_data <= k[23:16];
                ai_ch_pkg::ADDR_B:                  rd_data <= b[7:0];
                ai_ch_pkg::ADDR_B + 12'd1:          rd_data <= b[15:8];
                ai_ch_pkg::ADDR_B + 12'd2:          rd_data <= b[23:16];
                ai_ch_pkg::ADDR_RESULT:             rd_data <= proc_data[7:0];
                ai_ch_pkg::ADDR_RESULT + 12'd1:     rd_data <= proc_data[15:8];
                // limit flags in bits 3 and 2
                ai_ch_pkg::ADDR_STATUS:             rd_data <= {4'd0, low_flag, high_flag, 2'd0};
                default:                            rd_data <= 8'h00;
            endcase
        end
    end

endmodule

// ==== source/sample_conditioner.sv ====
module sample_conditioner (
    input  logic               clk,
    input  logic               rst_n,
    input  ai_ch_pkg::sample_t raw_sample,
    input  logic               sample_valid,
    input  ai_ch_pkg::sample_t k,
    input  ai_ch_pkg::sample_t b,
    input  ai_ch_pkg::byte_t   filter_type,
    input  ai_ch_pkg::byte_t   filter_factor,
    input  ai_ch_pkg::proc_t   high_limit,
    input  ai_ch_pkg::proc_t   low_limit,
    output ai_ch_pkg::proc_t   proc_data,
    output logic               high_flag,
    output logic               low_flag
);

    localparam logic [47:0] CAL_MAX = 48'hFF_FFFF << ai_ch_pkg::CAL_FRAC;

    logic [47:0]        prod;
    logic [47:0]        offs;
    logic [48:0]        acc;
    logic [47:0]        cal;
    ai_ch_pkg::sample_t cal_code;
    ai_ch_pkg::proc_t   hist [8];
    ai_ch_pkg::proc_t   filt;
    logic [16:0]        sum2;
    logic [17:0]        sum4;
    logic [18:0]        sum8;
    logic               upd;

    // code * k +/- |b| << 15, clamped to the 24 bit range
    assign prod = raw_sample * k;
    assign offs = {10'd0, b[22:0], 15'd0};
    assign acc  = b[23] ? ({1'b0, prod} - {1'b0, offs}) : ({1'b0, prod} + {1'b0, offs});

    always_comb begin
        if (b[23] && prod < offs)
            cal = '0;
        else if (acc > {1'b0, CAL_MAX})
            cal = CAL_MAX;
        else
            cal = acc[47:0];
    end

    assign cal_code = cal[ai_ch_pkg::CAL_FRAC +: 24];

    assign sum2 = 17'(hist[0]) + 17'(hist[1]);
    assign sum4 = 18'(sum2) + 18'(hist[2]) + 18'(hist[3]);
    assign sum8 = 19'(sum4) + 19'(hist[4]) + 19'(hist[5]) + 19'(hist[6]) + 19'(hist[7]);

    always_comb begin
        filt = '0;
        if (filter_type == ai_ch_pkg::FILT_NONE) begin
            filt = hist[0];
        end else if (filter_type == ai_ch_pkg::FILT_AVERAGE) begin
            case (filter_factor)
                8'd0:    filt = sum8[18:3];
                8'd1:    filt = sum4[17:2];
                8'd2:    filt = sum2[16:1];
                default: filt = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++)
                hist[i] <= '0;
            upd       <= 1'b0;
            proc_data <= '0;
        end else begin
            upd <= sample_valid;
            if (sample_valid) begin
                hist[0] <= cal_code[23:8];
                for (int i = 1; i < 8; i++)
                    hist[i] <= hist[i-1];
            end
            if (upd)
                proc_data <= filt;  // two cycles after the sample
        end
    end

    assign high_flag = proc_data > high_limit;
    assign low_flag  = proc_data < low_limit;

endmodule

// ==== source/spi_byte_engine.sv ====
module spi_byte_engine #(
    parameter int SPI_SPEED = 128
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start,
    input  ai_ch_pkg::byte_t [3:0] tx_bytes,
    input  logic [2:0]             n_tx,
    input  logic [2:0]             n_bytes,
    input  logic                   spi_miso,
    output logic                   busy,
    output ai_ch_pkg::byte_t       rx_byte,
    output logic                   rx_valid,
    output logic                   spi_clk,
    output logic                   spi_mosi,
    output logic                   spi_cs_n
);

    localparam int BIT_CYC  = SPI_SPEED / 8;
    localparam int HALF_CYC = SPI_SPEED / 16;
    localparam int CW       = $clog2(BIT_CYC);

    logic [CW-1:0]          cyc_cnt;
    logic [2:0]             bit_cnt;
    logic [2:0]             byte_cnt;
    logic [2:0]             next_idx;
    logic [2:0]             n_tx_r;
    logic [2:0]             n_bytes_r;
    logic                   byte_end;
    ai_ch_pkg::byte_t [3:0] tx_r;
    ai_ch_pkg::byte_t       tx_sr;
    ai_ch_pkg::byte_t       rx_sr;
    ai_ch_pkg::byte_t       next_byte;

    assign next_idx  = byte_cnt + 3'd1;
    assign next_byte = (next_idx < n_tx_r) ? tx_r[next_idx[1:0]] : 8'hFF;
    assign byte_end  = busy && cyc_cnt == CW'(BIT_CYC - 1) && bit_cnt == 3'd7;
    assign spi_mosi  = tx_sr[7];

    always_ff @(posedge clk) begin
        if (frame_start && !busy) begin
            tx_r      <= tx_bytes;
            n_tx_r    <= n_tx;
            n_bytes_r <= n_bytes;
        end
        if (busy && cyc_cnt == CW'(HALF_CYC - 1))
            rx_sr <= {rx_sr[6:0], spi_miso};  // on the rising edge
        if (byte_end)
            rx_byte <= rx_sr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode 3 timing, mosi moves with the falling edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            spi_cs_n <= 1'b1;
            spi_clk  <= 1'b1;
            tx_sr    <= 8'hFF;
            cyc_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (frame_start) begin
                    busy     <= 1'b1;
                    spi_cs_n <= 1'b0;
                    spi_clk  <= 1'b0;
                    tx_sr    <= (n_tx != 3'd0) ? tx_bytes[0] : 8'hFF;
                    cyc_cnt  <= '0;
                    bit_cnt  <= '0;
                    byte_cnt <= '0;
                end
            end else if (cyc_cnt == CW'(HALF_CYC - 1)) begin
                cyc_cnt <= cyc_cnt + 1'b1;
                spi_clk <= 1'b1;
            end else if (cyc_cnt == CW'(BIT_CYC - 1)) begin
                cyc_cnt <= '0;
                bit_cnt <= bit_cnt + 3'd1;
                if (!byte_end) begin
                    spi_clk <= 1'b0;
                    tx_sr   <= {tx_sr[6:0], 1'b1};
                end else begin
                    byte_cnt <= next_idx;
                    rx_valid <= (byte_cnt >= n_tx_r);  // only the trailing bytes
                    if (next_idx == n_bytes_r) begin
                        busy     <= 1'b0;
                        spi_cs_n <= 1'b1;
                        tx_sr    <= 8'hFF;
                    end else begin
                        spi_clk <= 1'b0;
                        tx_sr   <= next_byte;
                    end
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule
